// ==== logic/gpio_pkg.sv ====
// gpio shared definitions
// packet field positions, widths, block id field
// register map enum

`default_nettype none

package gpio_pkg;

   //########################################
   // widths
   //########################################
   localparam int unsigned gpio_aw = 32;           // address and data width
   localparam int unsigned gpio_pw = 2*gpio_aw+40; // mesh packet width, 104
   localparam int unsigned off_w   = 6;            // register offset width
   localparam int unsigned id_w    = 3;            // block id width

   //########################################
   // packet fields
   //########################################
   // datamode [2:1], ctrlmode [7:3], srcaddr [103:72] are not decoded here
   localparam int unsigned pkt_write_bit = 0;  // 1 = write, 0 = read
   localparam int unsigned pkt_dst_lsb   = 8;  // dstaddr [39:8]
   localparam int unsigned pkt_data_lsb  = 40; // data [71:40]

   // fields inside the destination address
   localparam int unsigned off_lsb = 2; // word offset, addr [7:2]
   localparam int unsigned id_lsb  = 8; // block id, addr [10:8]

   // register offsets, addr [7:2]
   typedef enum logic [off_w-1:0] {
      reg_odata    = 6'd0,
      reg_odataand = 6'd1,
      reg_odataorr = 6'd2,
      reg_odataxor = 6'd3,
      reg_oen      = 6'd4,
      reg_idata    = 6'd5,  // read only
      reg_itype    = 6'd6,
      reg_ipol     = 6'd7,
      reg_imask    = 6'd8,
      reg_imaskand = 6'd9,
      reg_imaskorr = 6'd10,
      reg_ilat     = 6'd11,
      reg_ilatand  = 6'd12  // last mapped offset
   } gpio_reg_e;

endpackage

`default_nettype wire

// ==== logic/gpio_reg_if.sv ====
// decoded register access bundle
// source side is the packet decoder, sink side the register blocks

`timescale 1ns/1ps
`default_nettype none

interface gpio_reg_if;

   logic                         wr;     // write strobe, one cycle
   logic                         rd;     // read strobe, one cycle
   gpio_pkg::gpio_reg_e          regsel; // register offset
   logic [gpio_pkg::gpio_aw-1:0] wdata;  // write data

   // decoder drives
   modport source (
      output wr,
      output rd,
      output regsel,
      output wdata
   );

   // register blocks and readback listen
   modport sink (
      input wr,
      input rd,
      input regsel,
      input wdata
   );

endinterface

`default_nettype wire

// ==== logic/gpio_packet_decode.sv ====
// mesh packet decoder
// block id match, offset decode, read and write strobes

`timescale 1ns/1ps
`default_nettype none

module gpio_packet_decode #(
   parameter logic [gpio_pkg::id_w-1:0] ID = '0  // block id to match
) (
   input  wire                            reg_access, // access strobe
   input  wire [gpio_pkg::gpio_pw-1:0]    reg_packet, // mesh packet
   gpio_reg_if.source                     bus         // decoded access
);

   logic                          write;    // packet write bit
   logic [gpio_pkg::gpio_aw-1:0]  dst_addr; // destination address
   logic [gpio_pkg::off_w-1:0]    offset;   // word offset
   logic [gpio_pkg::id_w-1:0]     blk_id;   // block id field
   logic                          match;    // access aimed at this block
   logic                          mapped;   // offset inside register map
   logic                          writable;

   //########################################
   // packet fields
   //########################################
   assign write    = reg_packet[gpio_pkg::pkt_write_bit];
   assign dst_addr = reg_packet[gpio_pkg::pkt_dst_lsb +: gpio_pkg::gpio_aw];
   assign offset   = dst_addr[gpio_pkg::off_lsb +: gpio_pkg::off_w];
   assign blk_id   = dst_addr[gpio_pkg::id_lsb +: gpio_pkg::id_w];

   // upper address bits are ignored
   assign match = reg_access & (blk_id == ID);

   //########################################
   // offset decode
   //########################################
   // map is dense from 0 up to ilatand
   assign mapped   = (offset <= gpio_pkg::reg_ilatand);
   // idata is input only, so writes to it drop here
   assign writable = mapped & (offset != gpio_pkg::reg_idata);

   assign bus.regsel = gpio_pkg::gpio_reg_e'(offset);
   assign bus.wdata  = reg_packet[gpio_pkg::pkt_data_lsb +: gpio_pkg::gpio_aw];

   // strobes, never both high
   assign bus.wr = match & write & writable;
   assign bus.rd = match & ~write; // unmapped reads resolve to zero downstream

endmodule

`default_nettype wire

// ==== logic/gpio_in_sync.sv ====
// input pin synchronizer
// two flop sync, shadow flop, rise and fall events

`timescale 1ns/1ps
`default_nettype none

module gpio_in_sync #(
   parameter int unsigned N = 24  // number of pins
) (
   input  wire          clk,
   input  wire          nreset,  // async, active low
   input  wire  [N-1:0] pins,    // raw pins, asynchronous
   output logic [N-1:0] sync,    // synchronized pins
   output logic [N-1:0] rise,    // one cycle, low to high
   output logic [N-1:0] fall     // one cycle, high to low
);

   logic [N-1:0] meta;    // first stage, may go metastable
   logic [N-1:0] shadow;  // sync delayed one cycle

   //########################################
   // synchronizer and shadow
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         meta   <= '0;
         sync   <= '0;
         shadow <= '0;
      end else begin
         meta   <= pins;   // edge 1
         sync   <= meta;   // edge 2, safe to use
         shadow <= sync;   // previous sync value
      end
   end

   // edge detect against previous value
   // each event holds for exactly one cycle
   assign rise = sync & ~shadow;
   assign fall = ~sync & shadow;

endmodule

`default_nettype wire

// ==== logic/gpio_out_ctrl.sv ====
// output control registers
// odata with load, and, or, xor writes
// oen tristate enables

`timescale 1ns/1ps
`default_nettype none

module gpio_out_ctrl #(
   parameter int unsigned N = 24  // number of pins
) (
   input  wire          clk,
   input  wire          nreset,  // async, active low
   gpio_reg_if.sink     bus,     // decoded register access
   output logic [N-1:0] odata,   // pin output data
   output logic [N-1:0] oen      // pin tristate enables
);

   logic [N-1:0] wdata_n;  // write data cut to pin count

   assign wdata_n = bus.wdata[N-1:0];

   //########################################
   // odata
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         odata <= '0;
      end else if (bus.wr) begin
         case (bus.regsel)
            gpio_pkg::reg_odata:    odata <= wdata_n;
            gpio_pkg::reg_odataand: odata <= odata & wdata_n; // clear bits
            gpio_pkg::reg_odataorr: odata <= odata | wdata_n; // set bits
            gpio_pkg::reg_odataxor: odata <= odata ^ wdata_n; // toggle bits
            default:                odata <= odata;
         endcase
      end
   end

   //########################################
   // oen
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         oen <= '0;
      end else if (bus.wr && (bus.regsel == gpio_pkg::reg_oen)) begin
         oen <= wdata_n;  // 1 drives the pin
      end
   end

endmodule

`default_nettype wire

// ==== logic/gpio_irq_ctrl.sv ====
// interrupt control
// itype, ipol, imask and ilat registers
// per pin event qualify, masked global interrupt

`timescale 1ns/1ps
`default_nettype none

module gpio_irq_ctrl #(
   parameter int unsigned N = 24  // number of pins
) (
   input  wire          clk,
   input  wire          nreset,  // async, active low
   gpio_reg_if.sink     bus,     // decoded register access
   input  wire  [N-1:0] sync,    // synchronized pins
   input  wire  [N-1:0] rise,    // rising events
   input  wire  [N-1:0] fall,    // falling events
   output logic [N-1:0] itype,   // 0 level, 1 edge
   output logic [N-1:0] ipol,    // 0 positive, 1 negative
   output logic [N-1:0] imask,   // 1 blocks pin from irq
   output logic [N-1:0] ilat,    // latched interrupts
   output logic         irq      // global interrupt
);

   logic [N-1:0] wdata_n;    // write data cut to pin count
   logic [N-1:0] evt;        // qualified event per pin
   logic [N-1:0] ilat_next;

   assign wdata_n = bus.wdata[N-1:0];

   //########################################
   // config registers
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         itype <= '0;
         ipol  <= '0;
         imask <= '0;
      end else if (bus.wr) begin
         case (bus.regsel)
            gpio_pkg::reg_itype:    itype <= wdata_n;
            gpio_pkg::reg_ipol:     ipol  <= wdata_n;
            gpio_pkg::reg_imask:    imask <= wdata_n;
            gpio_pkg::reg_imaskand: imask <= imask & wdata_n;
            gpio_pkg::reg_imaskorr: imask <= imask | wdata_n;
            default: ;
         endcase
      end
   end

   //########################################
   // event qualify
   //########################################
   assign evt = (~itype & ~ipol & sync)  |  // level, active high
                (~itype &  ipol & ~sync) |  // level, active low
                ( itype & ~ipol & rise)  |  // rising edge
                ( itype &  ipol & fall);    // falling edge

   // latch next value
   always_comb begin
      ilat_next = ilat;
      if (bus.wr && (bus.regsel == gpio_pkg::reg_ilatand)) begin
         ilat_next = ilat & wdata_n;   // zeros clear
      end
      if (bus.wr && (bus.regsel == gpio_pkg::reg_ilat)) begin
         ilat_next = ilat | wdata_n;   // ones set
      end
      ilat_next = ilat_next | evt;     // event beats a clear
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         ilat <= '0;
      end else begin
         ilat <= ilat_next;
      end
   end

   // unmasked latch bits reach the global line
   assign irq = |(ilat & ~imask);

endmodule

`default_nettype wire

// ==== logic/gpio_readback.sv ====
// register readback
// idata sample register, registered read mux

`timescale 1ns/1ps
`default_nettype none

module gpio_readback #(
   parameter int unsigned N = 24  // number of pins
) (
   input  wire                                clk,
   input  wire                                nreset,    // async, active low
   gpio_reg_if.sink                           bus,       // decoded register access
   input  wire  [N-1:0]                       odata,
   input  wire  [N-1:0]                       oen,
   input  wire  [N-1:0]                       idata_src, // synchronized pins
   input  wire  [N-1:0]                       itype,
   input  wire  [N-1:0]                       ipol,
   input  wire  [N-1:0]                       imask,
   input  wire  [N-1:0]                       ilat,
   output logic [gpio_pkg::gpio_aw-1:0]       rdata      // read data
);

   logic [N-1:0]                 idata;   // sampled pins
   logic [gpio_pkg::gpio_aw-1:0] rd_sel;  // zero extended selection

   // idata follows the sync output one cycle late
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) idata <= '0;
      else         idata <= idata_src;
   end

   //########################################
   // read mux
   //########################################
   always_comb begin
      rd_sel = '0;  // unmapped and set/clear aliases read zero
      case (bus.regsel)
         gpio_pkg::reg_odata: rd_sel[N-1:0] = odata;
         gpio_pkg::reg_oen:   rd_sel[N-1:0] = oen;
         gpio_pkg::reg_idata: rd_sel[N-1:0] = idata;
         gpio_pkg::reg_itype: rd_sel[N-1:0] = itype;
         gpio_pkg::reg_ipol:  rd_sel[N-1:0] = ipol;
         gpio_pkg::reg_imask: rd_sel[N-1:0] = imask;
         gpio_pkg::reg_ilat:  rd_sel[N-1:0] = ilat;
         default: ;
      endcase
   end

   // holds until the next read
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)     rdata <= '0;
      else if (bus.rd) rdata <= rd_sel;
   end

endmodule

`default_nettype wire

// ==== logic/gpio.sv ====
// gpio top level, up to 32 pins
// mesh packet register access, output and tristate control
// synchronized inputs with level and edge interrupts

`timescale 1ns/1ps
`default_nettype none

module gpio #(
   parameter int unsigned               N  = 24,  // number of pins, 1 to 32
   parameter logic [gpio_pkg::id_w-1:0] ID = '0   // block id, addr [10:8]
) (
   input  wire                           clk,
   input  wire                           nreset,     // async, active low
   input  wire                           reg_access, // register access strobe
   input  wire  [gpio_pkg::gpio_pw-1:0]  reg_packet, // mesh packet
   output logic [gpio_pkg::gpio_aw-1:0]  reg_rdata,  // readback data
   input  wire  [N-1:0]                  gpio_in,    // pin inputs
   output logic [N-1:0]                  gpio_out,   // pin output data
   output logic [N-1:0]                  gpio_en,    // pin tristate enables
   output logic                          gpio_irq,   // masked global interrupt
   output logic [gpio_pkg::gpio_aw-1:0]  gpio_ilat   // latch, zero extended
);

   logic [N-1:0] sync;   // synchronized pins
   logic [N-1:0] rise;
   logic [N-1:0] fall;
   logic [N-1:0] itype;
   logic [N-1:0] ipol;
   logic [N-1:0] imask;
   logic [N-1:0] ilat;

   gpio_reg_if bus ();  // decoder to register blocks

   //########################################
   // access decode
   //########################################
   gpio_packet_decode #(.ID(ID)) u_decode (
      .reg_access (reg_access),
      .reg_packet (reg_packet),
      .bus        (bus.source)
   );

   //########################################
   // pins and registers
   //########################################
   gpio_in_sync #(.N(N)) u_in_sync (
      .clk (clk), .nreset (nreset), .pins (gpio_in),
      .sync (sync), .rise (rise), .fall (fall)
   );

   gpio_out_ctrl #(.N(N)) u_out_ctrl (
      .clk (clk), .nreset (nreset), .bus (bus.sink),
      .odata (gpio_out), .oen (gpio_en)
   );

   gpio_irq_ctrl #(.N(N)) u_irq_ctrl (
      .clk (clk), .nreset (nreset), .bus (bus.sink),
      .sync (sync), .rise (rise), .fall (fall),
      .itype (itype), .ipol (ipol), .imask (imask), .ilat (ilat),
      .irq (gpio_irq)
   );

   gpio_readback #(.N(N)) u_readback (
      .clk (clk), .nreset (nreset), .bus (bus.sink),
      .odata (gpio_out), .oen (gpio_en), .idata_src (sync),
      .itype (itype), .ipol (ipol), .imask (imask), .ilat (ilat),
      .rdata (reg_rdata)
   );

   assign gpio_ilat = gpio_pkg::gpio_aw'(ilat);  // upper bits zero

endmodule

`default_nettype wire

// ==== bench/gpio_checker.sv ====
// gpio reference model and output compare
// register model, input sync model, per cycle checks

`timescale 1ns/1ps
`default_nettype none

module gpio_checker #(
   parameter int unsigned               N  = 24,  // number of pins
   parameter logic [gpio_pkg::id_w-1:0] ID = '0   // block id to match
) (
   input  wire                          clk,
   input  wire                          nreset,
   input  wire                          reg_access,
   input  wire [gpio_pkg::gpio_pw-1:0]  reg_packet,
   input  wire [N-1:0]                  gpio_in,
   input  wire [gpio_pkg::gpio_aw-1:0]  reg_rdata,
   input  wire [N-1:0]                  gpio_out,
   input  wire [N-1:0]                  gpio_en,
   input  wire                          gpio_irq,
   input  wire [gpio_pkg::gpio_aw-1:0]  gpio_ilat,
   output int                           errors,   // value mismatches
   output int                           checks,   // compares done
   output int                           hits      // accesses aimed at the DUT
);

   // input path model
   logic [N-1:0] m_meta;
   logic [N-1:0] m_sync;
   logic [N-1:0] m_shadow;
   logic [N-1:0] m_idata;
   // register model
   logic [N-1:0]  m_odata;
   logic [N-1:0]  m_oen;
   logic [N-1:0]  m_itype;
   logic [N-1:0]  m_ipol;
   logic [N-1:0]  m_imask;
   logic [N-1:0]  m_ilat;
   logic [31:0]   m_rdata;
   // decoded access for the model block
   logic          p_write;
   logic [31:0]   p_dst;
   logic [31:0]   p_data;
   logic [5:0]    p_off;
   logic [2:0]    p_id;
   logic          hit;
   logic          do_wr;
   logic          do_rd;
   logic [N-1:0]  wd;
   logic [N-1:0]  m_rise;
   logic [N-1:0]  m_fall;
   logic [N-1:0]  m_evt;
   int            k;
   logic          armed = 1'b0;  // compares start after first edge

   initial begin
      errors = 0;
      checks = 0;
      hits   = 0;
   end

   // model read view with aliases reading zero
   function automatic logic [31:0] selected_value(input logic [5:0] off);
      logic [31:0] v;
      v = '0;
      case (off)
         gpio_pkg::reg_odata: v[N-1:0] = m_odata;
         gpio_pkg::reg_oen:   v[N-1:0] = m_oen;
         gpio_pkg::reg_idata: v[N-1:0] = m_idata;
         gpio_pkg::reg_itype: v[N-1:0] = m_itype;
         gpio_pkg::reg_ipol:  v[N-1:0] = m_ipol;
         gpio_pkg::reg_imask: v[N-1:0] = m_imask;
         gpio_pkg::reg_ilat:  v[N-1:0] = m_ilat;
         default:             v = '0;
      endcase
      return v;
   endfunction

   task automatic compare_word(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0d ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   //########################################
   // model update once per edge
   //########################################
   always @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         m_meta   = '0;
         m_sync   = '0;
         m_shadow = '0;
         m_idata  = '0;
         m_odata  = '0;
         m_oen    = '0;
         m_itype  = '0;
         m_ipol   = '0;
         m_imask  = '0;
         m_ilat   = '0;
         m_rdata  = '0;
      end else begin
         p_write = reg_packet[gpio_pkg::pkt_write_bit];
         p_dst   = reg_packet[gpio_pkg::pkt_dst_lsb +: 32];
         p_data  = reg_packet[gpio_pkg::pkt_data_lsb +: 32];
         p_off   = p_dst[7:2];
         p_id    = p_dst[10:8];
         wd      = p_data[N-1:0];
         hit     = reg_access && (p_id == ID);
         // idata is read only and offsets past 12 are unmapped
         do_wr   = hit && p_write && (p_off <= 6'd12) && (p_off != 6'd5);
         do_rd   = hit && !p_write;
         if (hit) hits++;

         // events from state before this edge
         m_rise = m_sync & ~m_shadow;
         m_fall = ~m_sync & m_shadow;
         for (k = 0; k < N; k++) begin
            case ({m_itype[k], m_ipol[k]})
               2'b00:   m_evt[k] = m_sync[k];   // level high
               2'b01:   m_evt[k] = ~m_sync[k];  // level low
               2'b10:   m_evt[k] = m_rise[k];
               default: m_evt[k] = m_fall[k];
            endcase
         end

         if (do_rd) m_rdata = selected_value(p_off);  // old contents

         // latch clears and sets first and events go on top
         if (do_wr && (p_off == gpio_pkg::reg_ilatand)) m_ilat = m_ilat & wd;
         if (do_wr && (p_off == gpio_pkg::reg_ilat))    m_ilat = m_ilat | wd;
         m_ilat = m_ilat | m_evt;

         if (do_wr) begin
            case (p_off)
               gpio_pkg::reg_odata:    m_odata = wd;
               gpio_pkg::reg_odataand: m_odata = m_odata & wd;
               gpio_pkg::reg_odataorr: m_odata = m_odata | wd;
               gpio_pkg::reg_odataxor: m_odata = m_odata ^ wd;
               gpio_pkg::reg_oen:      m_oen   = wd;
               gpio_pkg::reg_itype:    m_itype = wd;
               gpio_pkg::reg_ipol:     m_ipol  = wd;
               gpio_pkg::reg_imask:    m_imask = wd;
               gpio_pkg::reg_imaskand: m_imask = m_imask & wd;
               gpio_pkg::reg_imaskorr: m_imask = m_imask | wd;
               default: ;
            endcase
         end

         // input chain updated last stage first
         m_idata  = m_sync;
         m_shadow = m_sync;
         m_sync   = m_meta;
         m_meta   = gpio_in;
      end
   end

   always @(posedge clk) armed <= 1'b1;

   //########################################
   // compare on falling edge
   //########################################
   always @(negedge clk) begin
      if (armed) begin
         compare_word("gpio_out", 32'(gpio_out), 32'(m_odata));
         compare_word("gpio_en", 32'(gpio_en), 32'(m_oen));
         compare_word("gpio_ilat", gpio_ilat, 32'(m_ilat));
         compare_word("gpio_irq", {31'b0, gpio_irq}, {31'b0, |(m_ilat & ~m_imask)});
         compare_word("reg_rdata", reg_rdata, m_rdata);
      end
   end

endmodule

`default_nettype wire

// ==== bench/gpio_tb.sv ====
// gpio testbench top
// clock, reset, lfsr random accesses and pins
// watchdog, closing report

`timescale 1ns/1ps
`default_nettype none

module gpio_tb;

   localparam int unsigned               N           = 24;
   localparam logic [gpio_pkg::id_w-1:0] ID          = 3'd0;
   localparam int                        n_access    = 400;
   localparam int                        watchdog_ns = n_access * 6 * 8 + 2000;

   logic                          clk;
   logic                          nreset;
   logic                          reg_access;
   logic [gpio_pkg::gpio_pw-1:0]  reg_packet;
   logic [N-1:0]                  gpio_in;
   wire  [gpio_pkg::gpio_aw-1:0]  reg_rdata;
   wire  [N-1:0]                  gpio_out;
   wire  [N-1:0]                  gpio_en;
   wire                           gpio_irq;
   wire  [gpio_pkg::gpio_aw-1:0]  gpio_ilat;

   int          value_errors;
   int          check_count;
   int          hit_count;
   int          sent;       // accesses driven
   int          pin_hold;   // cycles left before pins may change
   logic [15:0] lfsr;
   logic [31:0] gap;
   int          i;

   gpio #(.N(N), .ID(ID)) DUT (
      .clk (clk), .nreset (nreset),
      .reg_access (reg_access), .reg_packet (reg_packet), .reg_rdata (reg_rdata),
      .gpio_in (gpio_in), .gpio_out (gpio_out), .gpio_en (gpio_en),
      .gpio_irq (gpio_irq), .gpio_ilat (gpio_ilat)
   );

   gpio_checker #(.N(N), .ID(ID)) u_checker (
      .clk (clk), .nreset (nreset),
      .reg_access (reg_access), .reg_packet (reg_packet), .gpio_in (gpio_in),
      .reg_rdata (reg_rdata), .gpio_out (gpio_out), .gpio_en (gpio_en),
      .gpio_irq (gpio_irq), .gpio_ilat (gpio_ilat),
      .errors (value_errors), .checks (check_count), .hits (hit_count)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;  // 8 ns period
   end

   //########################################
   // random source
   //########################################
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic draw(input int n, output logic [31:0] v);
      int b;
      v = '0;
      for (b = 0; b < n; b++) begin
         lfsr = lfsr_next(lfsr);  // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // next edge, then drive 1 ns later
   task automatic step_cycle();
      logic [31:0] pick;
      logic [31:0] pins;
      @(posedge clk);
      #1;
      if (pin_hold > 0) begin
         pin_hold--;
      end else begin
         draw(3, pick);
         if (pick == 0) begin  // about one cycle in eight
            draw(N, pins);
            gpio_in  = pins[N-1:0];
            pin_hold = 4;
         end
      end
   endtask

   task automatic send_access();
      logic [31:0]                  wr;
      logic [31:0]                  id;
      logic [31:0]                  off;
      logic [31:0]                  low;
      logic [31:0]                  data;
      logic [31:0]                  mode;
      logic [gpio_pkg::gpio_pw-1:0] pkt;
      draw(1, wr);
      draw(3, id);    // matches about one in eight
      draw(4, off);   // 0 to 15, includes unmapped
      draw(2, low);
      draw(32, data);
      draw(7, mode);
      pkt = '0;
      pkt[gpio_pkg::pkt_write_bit] = wr[0];
      pkt[7:1] = mode[6:0];  // data and control mode, not decoded
      pkt[gpio_pkg::pkt_dst_lsb +: 32]  = {21'b0, id[2:0], 2'b00, off[3:0], low[1:0]};
      pkt[gpio_pkg::pkt_data_lsb +: 32] = data;
      reg_packet = pkt;
      reg_access = 1'b1;
      sent++;
      step_cycle();
      reg_access = 1'b0;  // single cycle strobe
   endtask

   task automatic print_summary(input int timeouts);
      $display("summary: %0d accesses, %0d matched, %0d checks, %0d value errors, %0d timeouts",
               sent, hit_count, check_count, value_errors, timeouts);
   endtask

   //########################################
   // stimulus
   //########################################
   initial begin
      reg_access = 1'b0;
      reg_packet = '0;
      gpio_in    = '0;
      nreset     = 1'b0;
      lfsr       = 16'd8;
      pin_hold   = 0;
      sent       = 0;
      repeat (5) @(posedge clk);
      #1;
      nreset = 1'b1;
      for (i = 0; i < n_access; i++) begin
         send_access();
         draw(2, gap);
         repeat (gap[1:0]) step_cycle();  // 0 to 3 idle cycles
      end
      repeat (8) step_cycle();  // let pins and last read settle
      @(negedge clk);
      #1;
      print_summary(0);
      if (value_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(watchdog_ns);
      $display("timeout: the access sequence did not finish within %0d ns", watchdog_ns);
      print_summary(1);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== gpio_sub.f ====
logic/gpio_pkg.sv
logic/gpio_reg_if.sv
logic/gpio_packet_decode.sv
logic/gpio_in_sync.sv
logic/gpio_out_ctrl.sv
logic/gpio_irq_ctrl.sv
logic/gpio_readback.sv
logic/gpio.sv
bench/gpio_checker.sv
bench/gpio_tb.sv
